// ==== hdl/dac_ctrl_pkg.sv ====
`default_nettype none

package dac_ctrl_pkg;

  // Command word layout
  localparam int CMD_W    = 32;
  localparam int DELAY_W  = 26;   // Delay count in bits 25:0
  localparam int TRIG_BIT = 29;   // Wait for trigger instead of delay
  localparam int CONT_BIT = 28;   // Another command must follow
  localparam int LDAC_BIT = 27;   // Pulse LDAC when the command ends

  // DAC side
  localparam int DAC_W   = 16;
  localparam int CH_W    = 3;
  localparam int N_CH    = 8;
  localparam int FRAME_W = 24;    // One AD5676 style write frame
  localparam logic signed [DAC_W:0] DAC_MID       = 17'sd32767; // Offset code for zero
  localparam logic [DAC_W-1:0]      DAC_FORBIDDEN = 16'hFFFF;   // No signed equivalent

  typedef enum logic [1:0] {
    CMD_NO_OP   = 2'b00,  // Delay or trigger wait
    CMD_DAC_WR  = 2'b01,  // Followed by four pair words
    CMD_SET_CAL = 2'b10,
    CMD_CANCEL  = 2'b11   // Ends a wait with no LDAC
  } cmd_op_e;

  typedef enum logic [2:0] {S_IDLE, S_DELAY, S_TRIG_WAIT, S_DAC_WR, S_ERROR} seq_state_e;

  typedef enum logic [3:0] {SPI_CMD_REG_WRITE = 4'b0001} spi_cmd_e;

  typedef enum logic [1:0] {LOAD_IDLE, LOAD_CAL, LOAD_CONV} load_stage_e;

  // Offset code to signed, 32767 maps to 0
  function automatic logic signed [DAC_W-1:0] offset_to_signed(input logic [DAC_W-1:0] val);
    logic signed [DAC_W:0] wide;
    wide = $signed({1'b0, val}) - DAC_MID;
    return wide[DAC_W-1:0];
  endfunction

  // Back to offset code, caller keeps val within +-DAC_MID
  function automatic logic [DAC_W-1:0] signed_to_offset(input logic signed [DAC_W:0] val);
    logic signed [DAC_W:0] wide;
    wide = val + DAC_MID;
    return wide[DAC_W-1:0];
  endfunction

  function automatic logic [FRAME_W-1:0] dac_write_frame(input spi_cmd_e cmd,
      input logic [CH_W-1:0] ch, input logic [DAC_W-1:0] val);
    return {cmd, 1'b0, ch, val};
  endfunction

endpackage

`default_nettype wire

// ==== hdl/cmd_sequencer.sv ====
`default_nettype none

module cmd_sequencer (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic [dac_ctrl_pkg::CMD_W-1:0] cmd_word,
  input  logic                           cmd_buf_empty,
  input  logic                           trigger,
  input  logic                           ldac_shared,
  input  logic                           pair_done,
  input  logic                           cal_oob,
  input  logic                           dac_val_oob,
  output logic                           cmd_word_rd_en,
  output logic                           cal_wr,
  output logic                           pair_valid,
  output logic [dac_ctrl_pkg::CH_W-1:0]  pair_base,
  output logic                           waiting_for_trig,
  output logic                           ldac,
  output logic                           cmd_buf_underflow,
  output logic                           unexp_trig,
  output logic                           state_error
);
  import dac_ctrl_pkg::*;

  localparam logic [CH_W-2:0] LAST_PAIR = (CH_W-1)'(N_CH / 2 - 1);

  seq_state_e         state;
  seq_state_e         next_state;     // Where the word at the buffer head leads
  cmd_op_e            op;
  logic               do_ldac;
  logic               wait_for_trig;
  logic               expect_next;
  logic [DELAY_W-1:0] delay_timer;
  logic [CH_W-2:0]    pair_cnt;       // Pairs finished in this DAC_WR
  logic               pair_req;       // A pair word is due this cycle
  logic               last_pair;
  logic               cmd_end;
  logic               take_cmd;
  logic               cancel_wait;
  logic               underflow_now;
  logic               trig_err_now;
  logic               err_now;
  logic               has_flags;      // NO_OP and DAC_WR carry TRIG/CONT/LDAC

  assign op        = cmd_op_e'(cmd_word[CMD_W-1 -: 2]);
  assign has_flags = (op == CMD_NO_OP) || (op == CMD_DAC_WR);
  assign last_pair = pair_done && (pair_cnt == LAST_PAIR);

  // Current command finishes this cycle
  assign cmd_end = (state == S_DELAY && delay_timer == '0)
                || (state == S_TRIG_WAIT && trigger)
                || (state == S_DAC_WR && last_pair && !wait_for_trig && delay_timer == '0);

  // A CANCEL at the head ends any wait at once
  assign cancel_wait = (state == S_DELAY || state == S_TRIG_WAIT)
                    && !cmd_buf_empty && op == CMD_CANCEL;
  assign take_cmd    = (state == S_IDLE || cmd_end) && !cmd_buf_empty && !cancel_wait;

  always_comb begin
    case (op)
      CMD_NO_OP:  next_state = cmd_word[TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
      CMD_DAC_WR: next_state = S_DAC_WR;
      default:    next_state = S_IDLE;   // SET_CAL and CANCEL finish in one cycle
    endcase
  end

  // Error sources
  assign underflow_now = (cmd_end && expect_next && cmd_buf_empty)
                      || (state == S_DAC_WR && pair_req && cmd_buf_empty);
  assign trig_err_now  = (trigger && state != S_TRIG_WAIT)
                      || (ldac_shared && state == S_DAC_WR); // Outside LDAC during a write
  assign err_now       = underflow_now || trig_err_now || cal_oob || dac_val_oob;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= S_IDLE;
    end else if (err_now) begin
      state <= S_ERROR;
    end else if (state == S_ERROR) begin
      state <= S_ERROR;                  // Locked until reset
    end else if (cancel_wait) begin
      state <= S_IDLE;
    end else if (take_cmd) begin
      state <= next_state;
    end else if (cmd_end) begin
      state <= S_IDLE;                   // Done, buffer empty
    end else if (state == S_DAC_WR && last_pair) begin
      state <= wait_for_trig ? S_TRIG_WAIT : S_DELAY;
    end
  end

  // Command bits, held for the life of the command
  always_ff @(posedge clk) begin
    if (!resetn) begin
      do_ldac       <= 1'b0;
      wait_for_trig <= 1'b0;
      expect_next   <= 1'b0;
    end else if (take_cmd || cancel_wait) begin
      do_ldac       <= take_cmd && has_flags && cmd_word[LDAC_BIT];
      wait_for_trig <= take_cmd && has_flags && cmd_word[TRIG_BIT];
      expect_next   <= take_cmd && has_flags && cmd_word[CONT_BIT];
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      delay_timer <= '0;
    end else if (cancel_wait) begin
      delay_timer <= '0;
    end else if (take_cmd && has_flags) begin
      delay_timer <= cmd_word[TRIG_BIT] ? '0 : cmd_word[DELAY_W-1:0]; // Starts at pop
    end else if (delay_timer != '0) begin
      delay_timer <= delay_timer - 1'b1;
    end
  end

  // Pair word requests, first one right after the DAC_WR pop
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pair_req <= 1'b0;
      pair_cnt <= '0;
    end else begin
      pair_req <= (take_cmd && op == CMD_DAC_WR)
               || (state == S_DAC_WR && pair_done && !last_pair);
      if (take_cmd && op == CMD_DAC_WR) begin
        pair_cnt <= '0;
      end else if (state == S_DAC_WR && pair_done) begin
        pair_cnt <= pair_cnt + 1'b1;
      end
    end
  end

  assign pair_valid     = pair_req && !cmd_buf_empty && state == S_DAC_WR;
  assign pair_base      = {pair_cnt, 1'b0};   // Even channel of the pair
  assign cal_wr         = take_cmd && op == CMD_SET_CAL;
  assign cmd_word_rd_en = take_cmd || cancel_wait || pair_valid;

  // One cycle LDAC after a command ends, never on cancel
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ldac <= 1'b0;
    end else begin
      ldac <= cmd_end && do_ldac && !cancel_wait && !err_now;
    end
  end

  // Sticky flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmd_buf_underflow <= 1'b0;
      unexp_trig        <= 1'b0;
    end else begin
      if (underflow_now) cmd_buf_underflow <= 1'b1;
      if (trig_err_now)  unexp_trig        <= 1'b1;
    end
  end

  assign waiting_for_trig = (state == S_TRIG_WAIT);
  assign state_error      = (state == S_ERROR);

  a_no_ldac_in_error: assert property (@(posedge clk) disable iff (!resetn)
    state == S_ERROR |-> !ldac);

  // A pair word is never decoded as a command in the same cycle
  a_pair_pop_alone: assert property (@(posedge clk) disable iff (!resetn)
    pair_valid |-> !take_cmd);

endmodule

`default_nettype wire

// ==== hdl/cal_table.sv ====
`default_nettype none

module cal_table #(
  parameter int ABS_CAL_MAX = 4096   // Largest accepted |calibration|
) (
  input  logic                                 clk,
  input  logic                                 resetn,
  input  logic                                 cal_wr,
  input  logic [dac_ctrl_pkg::CMD_W-1:0]       cmd_word,
  input  logic [dac_ctrl_pkg::CH_W-1:0]        cal_ch,
  output logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_lo,
  output logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_hi,
  output logic                                 cal_oob
);
  import dac_ctrl_pkg::*;

  logic signed [DAC_W-1:0] cal_val [N_CH];
  logic signed [DAC_W-1:0] wr_val;
  logic [CH_W-1:0]         wr_ch;
  logic [CH_W-1:0]         hi_ch;
  logic                    in_bounds;

  assign wr_val    = $signed(cmd_word[DAC_W-1:0]);   // Value field, two's complement
  assign wr_ch     = cmd_word[16 +: CH_W];           // Channel in bits 18:16
  assign in_bounds = (wr_val <= ABS_CAL_MAX) && (wr_val >= -ABS_CAL_MAX);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < N_CH; i++) begin
        cal_val[i] <= '0;
      end
      cal_oob <= 1'b0;
    end else if (cal_wr) begin
      if (in_bounds) cal_val[wr_ch] <= wr_val;
      else           cal_oob        <= 1'b1;   // Write dropped
    end
  end

  // Both channels of the pair being calibrated
  assign hi_ch  = cal_ch + 1'b1;
  assign cal_lo = cal_val[cal_ch];
  assign cal_hi = cal_val[hi_ch];

endmodule

`default_nettype wire

// ==== hdl/dac_value_pipeline.sv ====
`default_nettype none

module dac_value_pipeline (
  input  logic                                  clk,
  input  logic                                  resetn,
  input  logic                                  pair_valid,
  input  logic [dac_ctrl_pkg::CMD_W-1:0]        pair_word,
  input  logic [dac_ctrl_pkg::CH_W-1:0]         pair_base,
  input  logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_lo,
  input  logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_hi,
  output logic [dac_ctrl_pkg::CH_W-1:0]         cal_ch,
  output logic                                  frame_load,
  output logic [2*dac_ctrl_pkg::FRAME_W-1:0]    frame_pair,
  output logic                                  dac_val_oob
);
  import dac_ctrl_pkg::*;

  load_stage_e             stage;
  logic signed [DAC_W-1:0] lo_sig;     // Lower half, pair_base
  logic signed [DAC_W-1:0] hi_sig;     // Upper half, pair_base+1
  logic signed [DAC_W:0]   lo_sum;
  logic signed [DAC_W:0]   hi_sum;
  logic [CH_W-1:0]         hi_ch;
  logic                    forbidden;
  logic                    sum_oob;

  assign forbidden = (pair_word[DAC_W-1:0] == DAC_FORBIDDEN)
                  || (pair_word[CMD_W-1 -: DAC_W] == DAC_FORBIDDEN);

  // Calibrated result must map back into 0..65534
  assign sum_oob = (lo_sum > DAC_MID) || (lo_sum < -DAC_MID)
                || (hi_sum > DAC_MID) || (hi_sum < -DAC_MID);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      stage       <= LOAD_IDLE;
      dac_val_oob <= 1'b0;
    end else begin
      case (stage)
        LOAD_IDLE: begin
          if (pair_valid) begin
            if (forbidden) dac_val_oob <= 1'b1;   // No frame for this pair
            else           stage       <= LOAD_CAL;
          end
        end
        LOAD_CAL:  stage <= LOAD_CONV;
        LOAD_CONV: begin
          if (sum_oob) dac_val_oob <= 1'b1;
          stage <= LOAD_IDLE;
        end
        default:   stage <= LOAD_IDLE;
      endcase
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    if (stage == LOAD_IDLE && pair_valid) begin
      lo_sig <= offset_to_signed(pair_word[DAC_W-1:0]);
      hi_sig <= offset_to_signed(pair_word[CMD_W-1 -: DAC_W]);
      cal_ch <= pair_base;   // Also selects the table entries
    end
    if (stage == LOAD_CAL) begin
      lo_sum <= lo_sig + cal_lo;   // 17 bit, cannot overflow
      hi_sum <= hi_sig + cal_hi;
    end
  end

  assign hi_ch      = cal_ch + 1'b1;
  assign frame_load = (stage == LOAD_CONV) && !sum_oob;

  // Lower channel frame sits on top, it goes out first
  assign frame_pair = {dac_write_frame(SPI_CMD_REG_WRITE, cal_ch, signed_to_offset(lo_sum)),
                       dac_write_frame(SPI_CMD_REG_WRITE, hi_ch, signed_to_offset(hi_sum))};

endmodule

`default_nettype wire

// ==== hdl/spi_frame_tx.sv ====
`default_nettype none

module spi_frame_tx #(
  parameter int N_CS_HIGH = 18   // n_cs high cycles before each frame
) (
  input  logic                               clk,
  input  logic                               resetn,
  input  logic                               frame_load,
  input  logic                               halt,
  input  logic [2*dac_ctrl_pkg::FRAME_W-1:0] frame_pair,
  output logic                               n_cs,
  output logic                               mosi,
  output logic                               pair_done
);
  import dac_ctrl_pkg::*;

  localparam int CNT_MAX = (N_CS_HIGH > FRAME_W) ? N_CS_HIGH : FRAME_W;
  localparam int CNT_W   = $clog2(CNT_MAX);
  localparam logic [CNT_W-1:0] GAP_LAST = CNT_W'(N_CS_HIGH - 1);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(FRAME_W - 1);

  logic                 busy;       // Pair in flight
  logic                 cs_q;       // Low while bits are shifting
  logic                 second;     // Working on the second frame
  logic [CNT_W-1:0]     cnt;        // Gap timer or bit counter
  logic [2*FRAME_W-1:0] shreg;
  logic                 gap_end;
  logic                 bit_end;

  assign gap_end   = busy && cs_q && cnt == '0;
  assign bit_end   = busy && !cs_q && cnt == '0;
  assign pair_done = bit_end && second;   // Last bit of the upper frame
  assign n_cs      = cs_q || halt;
  assign mosi      = shreg[2*FRAME_W-1];  // MSB first

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy   <= 1'b0;
      cs_q   <= 1'b1;
      second <= 1'b0;
      cnt    <= '0;
    end else if (halt) begin
      busy <= 1'b0;
      cs_q <= 1'b1;
    end else if (frame_load) begin
      busy   <= 1'b1;
      second <= 1'b0;
      cnt    <= GAP_LAST;
    end else if (gap_end) begin
      cs_q <= 1'b0;
      cnt  <= BIT_LAST;
    end else if (bit_end) begin
      cs_q   <= 1'b1;
      cnt    <= GAP_LAST;   // Spacing before the next frame
      second <= 1'b1;
      busy   <= !second;
    end else if (busy) begin
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_load) begin
      shreg <= frame_pair;
    end else if (busy && !cs_q) begin
      shreg <= {shreg[2*FRAME_W-2:0], 1'b0};
    end
  end

  // DAC needs at least 3 cycles of n_cs high to latch a frame
  a_cs_high_min: assert property (@(posedge clk) N_CS_HIGH >= 3);

  a_no_load_in_flight: assert property (@(posedge clk) disable iff (!resetn)
    frame_load |-> !busy);

endmodule

`default_nettype wire

// ==== hdl/dac_ctrl_top.sv ====
`default_nettype none

module dac_ctrl_top #(
  parameter int ABS_CAL_MAX = 4096,
  parameter int N_CS_HIGH   = 18
) (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic [dac_ctrl_pkg::CMD_W-1:0] cmd_word,
  input  logic                           cmd_buf_empty,
  input  logic                           trigger,
  input  logic                           ldac_shared,
  output logic                           cmd_word_rd_en,
  output logic                           waiting_for_trig,
  output logic                           ldac,
  output logic                           n_cs,
  output logic                           mosi,
  output logic                           cmd_buf_underflow,
  output logic                           unexp_trig,
  output logic                           cal_oob,
  output logic                           dac_val_oob,
  output logic                           state_error
);
  import dac_ctrl_pkg::*;

  logic                    cal_wr;
  logic                    pair_valid;
  logic                    pair_done;
  logic                    frame_load;
  logic [CH_W-1:0]         pair_base;
  logic [CH_W-1:0]         cal_ch;      // Pair being calibrated
  logic signed [DAC_W-1:0] cal_lo;
  logic signed [DAC_W-1:0] cal_hi;
  logic [2*FRAME_W-1:0]    frame_pair;

  cmd_sequencer i_cmd_sequencer (
    .clk, .resetn, .cmd_word, .cmd_buf_empty, .trigger, .ldac_shared,
    .pair_done, .cal_oob, .dac_val_oob, .cmd_word_rd_en, .cal_wr, .pair_valid,
    .pair_base, .waiting_for_trig, .ldac, .cmd_buf_underflow, .unexp_trig, .state_error
  );

  cal_table #(.ABS_CAL_MAX(ABS_CAL_MAX)) i_cal_table (
    .clk, .resetn, .cal_wr, .cmd_word, .cal_ch, .cal_lo, .cal_hi, .cal_oob
  );

  // Pair words come straight off the command port
  dac_value_pipeline i_dac_value_pipeline (
    .clk, .resetn, .pair_valid, .pair_word(cmd_word), .pair_base, .cal_lo, .cal_hi,
    .cal_ch, .frame_load, .frame_pair, .dac_val_oob
  );

  spi_frame_tx #(.N_CS_HIGH(N_CS_HIGH)) i_spi_frame_tx (
    .clk, .resetn, .frame_load, .halt(state_error), .frame_pair, .n_cs, .mosi, .pair_done
  );

endmodule

`default_nettype wire

// ==== verification/tb_spi_capture.sv ====
`default_nettype none

module tb_spi_capture (
  input  wire logic clk,
  input  wire logic resetn,
  input  wire logic n_cs,
  input  wire logic mosi,
  output int        errors
);
  import dac_ctrl_pkg::*;

  logic [FRAME_W-1:0] exp_q [$];   // Frames still to come, oldest first
  logic [FRAME_W-1:0] shift_in;
  logic [FRAME_W-1:0] exp_frame;
  int                 bit_cnt = 0;
  int                 err_cnt = 0;

  assign errors = err_cnt;

  task automatic expect_frame(input logic [FRAME_W-1:0] frame);
    exp_q.push_back(frame);
  endtask

  function automatic int pending_frames();
    return exp_q.size();
  endfunction

  // mosi is sampled while n_cs is low, MSB first
  always @(posedge clk) begin
    if (!resetn) begin
      exp_q.delete();
      bit_cnt = 0;
    end else if (n_cs) begin
      if (bit_cnt != 0) begin
        err_cnt++;
        $display("frame cut short after %0d bits at time %0t", bit_cnt, $time);
      end
      bit_cnt = 0;
    end else begin
      shift_in = {shift_in[FRAME_W-2:0], mosi};
      bit_cnt++;
      if (bit_cnt == FRAME_W) begin
        bit_cnt = 0;
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("frame %h arrived while none was expected", shift_in);
        end else begin
          exp_frame = exp_q.pop_front();
          assert (shift_in == exp_frame) else begin
            err_cnt++;
            $display("error %0t: frame %h, expected %h", $time, shift_in, exp_frame);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_dac_ctrl.sv ====
`default_nettype none

module tb_dac_ctrl;
  import dac_ctrl_pkg::*;

  localparam int ABS_CAL_MAX     = 4096;
  localparam int N_CS_HIGH       = 18;
  localparam int LDAC_DELAY      = 20;
  localparam int CANCEL_DELAY    = 300;
  localparam int UNDERFLOW_DELAY = 5;
  localparam int WR_DELAY        = 10;
  localparam int TRIG_HOLD       = 20;
  localparam int N_DAC_WR        = 3;
  localparam int PAIR_CYCLES     = 2 * (N_CS_HIGH + FRAME_W);  // One pair on the wire
  localparam int WATCHDOG_CYCLES = LDAC_DELAY + CANCEL_DELAY + UNDERFLOW_DELAY + 2 * WR_DELAY
                                 + 2 * TRIG_HOLD + N_DAC_WR * 8 * (N_CS_HIGH + FRAME_W) + 1000;

  logic             clk;
  logic             resetn = 1'b0;
  logic [CMD_W-1:0] cmd_word = '0;
  logic             cmd_buf_empty = 1'b1;
  logic             trigger = 1'b0;
  logic             ldac_shared = 1'b0;
  logic             cmd_word_rd_en;
  logic             waiting_for_trig;
  logic             ldac;
  logic             n_cs;
  logic             mosi;
  logic             cmd_buf_underflow;
  logic             unexp_trig;
  logic             cal_oob;
  logic             dac_val_oob;
  logic             state_error;
  logic [3:0]       flags;

  logic [CMD_W-1:0] cmd_q [$];             // Command buffer, head at index 0
  logic [31:0]      rng_state = 32'hc19b_34bd;
  int               cal_model [N_CH];      // Calibration the DUT should hold
  int               errors = 0;
  int               cap_errors;
  int               cyc = 0;
  int               ldac_cnt = 0;
  int               ldac_cyc = 0;
  int               pop_cyc = 0;

  assign flags = {cmd_buf_underflow, unexp_trig, cal_oob, dac_val_oob};

  dac_ctrl_top #(.ABS_CAL_MAX(ABS_CAL_MAX), .N_CS_HIGH(N_CS_HIGH)) i_dac_ctrl_top (
    .clk, .resetn, .cmd_word, .cmd_buf_empty, .trigger, .ldac_shared, .cmd_word_rd_en,
    .waiting_for_trig, .ldac, .n_cs, .mosi, .cmd_buf_underflow, .unexp_trig, .cal_oob,
    .dac_val_oob, .state_error
  );

  tb_spi_capture i_spi_capture (.clk, .resetn, .n_cs, .mosi, .errors(cap_errors));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // First word fall through buffer, head shows while not empty
  always @(posedge clk) begin
    if (resetn && cmd_word_rd_en && !cmd_buf_empty && cmd_q.size() > 0) void'(cmd_q.pop_front());
    cmd_buf_empty <= (cmd_q.size() == 0);
    cmd_word      <= (cmd_q.size() != 0) ? cmd_q[0] : '0;
  end

  always @(posedge clk) begin
    cyc++;
    if (resetn && ldac) begin
      ldac_cnt++;
      ldac_cyc = cyc;
    end
    if (resetn && cmd_word_rd_en && !cmd_buf_empty) pop_cyc = cyc;  // Last word taken
  end

  a_error_locks_outputs: assert property (@(posedge clk) disable iff (!resetn)
    state_error |-> n_cs && !ldac && !cmd_word_rd_en)
    else log_mismatch("outputs not held while locked in error");

  a_ldac_one_cycle: assert property (@(posedge clk) disable iff (!resetn) ldac |=> !ldac)
    else log_mismatch("ldac high for more than one cycle");

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [CMD_W-1:0] flagged_cmd(input cmd_op_e op, input bit trig,
      input bit cont, input bit ld, input int delay);
    return {op, trig, cont, ld, 1'b0, DELAY_W'(delay)};
  endfunction

  function automatic logic [CMD_W-1:0] cal_cmd(input int ch, input int val);
    return {CMD_SET_CAL, 11'd0, 3'(ch), 16'(val)};   // Channel 18:16, value 15:0
  endfunction

  task automatic log_mismatch(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    cmd_q.delete();
    for (int ch = 0; ch < N_CH; ch++) cal_model[ch] = 0;
    @(posedge clk);
    resetn  <= 1'b0;
    trigger <= 1'b0;
    repeat (3) @(posedge clk);
    resetn <= 1'b1;
  endtask

  task automatic pulse_trigger();
    @(posedge clk);
    trigger <= 1'b1;
    @(posedge clk);
    trigger <= 1'b0;
  endtask

  task automatic wait_drained(input int bound);
    int n = 0;
    @(negedge clk);
    while ((cmd_q.size() != 0 || !cmd_buf_empty) && n < bound) begin
      @(negedge clk);
      n++;
    end
    if (cmd_q.size() != 0 || !cmd_buf_empty) note_failure("command buffer not drained in time");
  endtask

  task automatic wait_ldac(input int start, input int bound);
    int n = 0;
    while (ldac_cnt == start && n < bound) begin
      @(negedge clk);
      n++;
    end
    if (ldac_cnt == start) note_failure("no ldac pulse seen in time");
  endtask

  task automatic wait_trig_state(input int bound);
    int n = 0;
    while (!waiting_for_trig && n < bound) begin
      @(negedge clk);
      n++;
    end
    if (!waiting_for_trig) note_failure("sequencer never started waiting for trigger");
  endtask

  task automatic check_idle();
    @(negedge clk);
    assert (n_cs && !ldac && !cmd_word_rd_en && !waiting_for_trig && flags == 4'b0 && !state_error)
      else log_mismatch("outputs not at their reset values");
  endtask

  task automatic set_calibration(input int ch, input int val);
    @(negedge clk);
    cmd_q.push_back(cal_cmd(ch, val));
    if (val <= ABS_CAL_MAX && val >= -ABS_CAL_MAX) cal_model[ch] = val;  // Else dropped
    wait_drained(20);
  endtask

  // Narrow keeps the calibrated value inside the offset range
  task automatic send_dac_write(input bit narrow);
    logic [DAC_W-1:0] val [N_CH];
    int               start;
    for (int ch = 0; ch < N_CH; ch++) begin
      rng_state = next_random(rng_state);
      if (narrow) val[ch] = DAC_W'(4096 + rng_state % 57343);
      else val[ch] = (rng_state[15:0] == 16'hFFFF) ? 16'hFFFE : rng_state[15:0];
      i_spi_capture.expect_frame({4'b0001, 1'b0, 3'(ch), DAC_W'(int'(val[ch]) + cal_model[ch])});
    end
    start = ldac_cnt;
    @(negedge clk);
    cmd_q.push_back(flagged_cmd(CMD_DAC_WR, 1'b0, 1'b0, 1'b1, WR_DELAY));
    for (int p = 0; p < N_CH / 2; p++) cmd_q.push_back({val[2*p+1], val[2*p]});  // Low = even
    wait_ldac(start, 4 * PAIR_CYCLES + WR_DELAY + 50);
    repeat (4) @(negedge clk);
    assert (i_spi_capture.pending_frames() == 0 && ldac_cnt == start + 1 && !state_error)
      else log_mismatch($sformatf("write left %0d frames, %0d ldac pulses",
                                  i_spi_capture.pending_frames(), ldac_cnt - start));
  endtask

  task automatic check_delay_ldac();
    int start;
    start = ldac_cnt;
    @(negedge clk);
    cmd_q.push_back(flagged_cmd(CMD_NO_OP, 1'b0, 1'b0, 1'b1, LDAC_DELAY));
    wait_ldac(start, LDAC_DELAY + 20);
    repeat (5) @(negedge clk);
    assert (ldac_cnt == start + 1 && ldac_cyc - pop_cyc == LDAC_DELAY + 2)   // Load, count, pulse
      else log_mismatch($sformatf("%0d ldac pulses, %0d cycles after pop",
                                  ldac_cnt - start, ldac_cyc - pop_cyc));
  endtask

  task automatic check_trigger_ldac();
    int start;
    start = ldac_cnt;
    @(negedge clk);
    cmd_q.push_back(flagged_cmd(CMD_NO_OP, 1'b1, 1'b0, 1'b1, 0));
    wait_trig_state(20);
    repeat (TRIG_HOLD) begin
      @(negedge clk);
      assert (waiting_for_trig && ldac_cnt == start) else log_mismatch("wait ended before trigger");
    end
    pulse_trigger();
    wait_ldac(start, 5);
    @(negedge clk);
    assert (!waiting_for_trig && ldac_cnt == start + 1 && !state_error)
      else log_mismatch("trigger did not end the wait with one ldac pulse");
  endtask

  task automatic check_cancel();
    int start;
    start = ldac_cnt;
    @(negedge clk);
    cmd_q.push_back(flagged_cmd(CMD_NO_OP, 1'b1, 1'b0, 1'b1, 0));
    wait_trig_state(20);
    @(negedge clk);
    cmd_q.push_back({CMD_CANCEL, 30'd0});
    wait_drained(20);
    @(negedge clk);
    cmd_q.push_back(flagged_cmd(CMD_NO_OP, 1'b0, 1'b0, 1'b1, CANCEL_DELAY));
    cmd_q.push_back({CMD_CANCEL, 30'd0});   // Cancels the delay just started
    wait_drained(20);
    repeat (CANCEL_DELAY + 10) @(negedge clk);
    assert (ldac_cnt == start && !waiting_for_trig && !state_error)
      else log_mismatch($sformatf("%0d ldac pulses after cancelled waits", ldac_cnt - start));
  endtask

  task automatic expect_lock(input logic [3:0] flag_exp, input string what);
    int n = 0;
    while (!state_error && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!state_error) begin
      note_failure({"no error state after ", what});
    end else begin
      repeat (20) begin
        assert (state_error && n_cs && !ldac && !cmd_word_rd_en && flags == flag_exp)
          else log_mismatch($sformatf("%s: flags %b, expected %b", what, flags, flag_exp));
        @(negedge clk);
      end
    end
  endtask

  initial begin
    int total;
    apply_reset();
    check_idle();
    send_dac_write(1'b0);
    set_calibration(1, 100);
    set_calibration(2, -1500);
    set_calibration(4, ABS_CAL_MAX);
    set_calibration(7, -ABS_CAL_MAX);
    send_dac_write(1'b1);
    check_delay_ldac();
    check_trigger_ldac();
    check_cancel();
    // Each error in its own reset epoch
    apply_reset();
    set_calibration(3, ABS_CAL_MAX + 1);
    expect_lock(4'b0010, "out of range calibration");
    apply_reset();
    @(negedge clk);
    cmd_q.push_back(flagged_cmd(CMD_DAC_WR, 1'b0, 1'b0, 1'b0, 0));
    cmd_q.push_back({16'h1234, DAC_FORBIDDEN});
    expect_lock(4'b0001, "forbidden DAC value");
    apply_reset();
    pulse_trigger();
    expect_lock(4'b0100, "trigger outside a wait");
    apply_reset();
    @(negedge clk);
    cmd_q.push_back(flagged_cmd(CMD_NO_OP, 1'b0, 1'b1, 1'b0, UNDERFLOW_DELAY));
    expect_lock(4'b1000, "continue bit with empty buffer");
    total = errors + cap_errors;
    $display("errors: %0d testbench, %0d frame, %0d total", errors, cap_errors, total);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/dac_ctrl_pkg.sv
hdl/cmd_sequencer.sv
hdl/cal_table.sv
hdl/dac_value_pipeline.sv
hdl/spi_frame_tx.sv
hdl/dac_ctrl_top.sv
verification/tb_spi_capture.sv
verification/tb_dac_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dac_ctrl
FILE_LIST ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILE_LIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "No result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
